//--- hackComputer.f
design/hackPkg.sv
design/hackAlu.sv
design/hackPc.sv
design/hackRam.sv
design/hackCpu.sv
design/hackMemoryMap.sv
design/hackComputer.sv
verif/hackComputerTb.sv

//--- Makefile
TOP := hackComputerTb

.PHONY: all run lint clean

all: run

build/V$(TOP): hackComputer.f $(wildcard design/*.sv) $(wildcard verif/*.sv)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) --Mdir build -f hackComputer.f

run: build/V$(TOP)
	@out=$$(./build/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f hackComputer.f

clean:
	rm -rf build

//--- verif/hackComputerTb.sv
`timescale 1ns/1ps

module hackComputerTb;
    import hackPkg::*;

    localparam int maxSteps     = 256;          // Table capacity
    localparam int sampleOffset = 2;            // Mid low phase, inputs settled
    localparam logic [5:0] compList [18] = '{
        6'b101010, 6'b111111, 6'b111010, 6'b001100, 6'b110000, 6'b001101,
        6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111, 6'b001110,
        6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101
    };
    localparam logic [5:0] dSetComp [3] = '{6'b111010, 6'b101010, 6'b111111};   // -1 0 1

    logic      clock;
    logic      rstN;
    logic      progWe;
    hackAddr_t progAddr;
    hackWord_t progData;
    logic      keyValid;
    hackWord_t keyCode;
    memReq_t   memReqOut;
    hackAddr_t pc;
    hackWord_t inM;

    hackWord_t progTab [0:maxSteps-1];          // Word per ROM address
    logic      keyTab [0:maxSteps-1];           // Strobe keyboard in this cycle
    hackWord_t keyCodeTab [0:maxSteps-1];
    int        tabLen;

    hackWord_t aModel;                          // Reference machine state
    hackWord_t dModel;
    hackAddr_t pcModel;
    hackWord_t kbdModel;
    hackWord_t memModel [int];                  // Written words only

    int seed;
    int errors;
    int steps;
    int cycles     = 0;
    int cycleLimit = 0;

    hackComputer #(.ramAddrBits(14), .romAddrBits(15)) UUT (
        .clock     (clock),
        .rstN      (rstN),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .keyValid  (keyValid),
        .keyCode   (keyCode),
        .memReqOut (memReqOut),
        .pc        (pc),
        .inM       (inM)
    );

    always #4 clock = ~clock;                   // 8 ns period

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, program never ran to its end", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic hackWord_t encodeA(input logic [14:0] value);
        return {1'b0, value};
    endfunction

    function automatic hackWord_t encodeC(input logic aSel, input logic [5:0] comp,
                                          input logic [2:0] dest, input logic [2:0] jump);
        return {3'b111, aSel, comp, dest, jump};
    endfunction

    // Hack comp table, D is x and A or M is y
    function automatic hackWord_t refAlu(input logic [5:0] comp, input hackWord_t d,
                                         input hackWord_t y);
        case (comp)
            6'b101010: return 16'd0;
            6'b111111: return 16'd1;
            6'b111010: return 16'hffff;
            6'b001100: return d;
            6'b110000: return y;
            6'b001101: return ~d;
            6'b110001: return ~y;
            6'b001111: return -d;
            6'b110011: return -y;
            6'b011111: return d + 16'd1;
            6'b110111: return y + 16'd1;
            6'b001110: return d - 16'd1;
            6'b110010: return y - 16'd1;
            6'b000010: return d + y;
            6'b010011: return d - y;
            6'b000111: return y - d;
            6'b000000: return d & y;
            6'b010101: return d | y;
            default:   return 16'd0;            // Undefined, never in the program
        endcase
    endfunction

    // Returns 1 when the word at addr is known to the model
    function automatic logic modelRead(input hackAddr_t addr, output hackWord_t value);
        value = '0;
        if (addr == KBD_ADDR) begin
            value = kbdModel;
            return 1'b1;
        end
        if (addr > KBD_ADDR) begin
            return 1'b1;                        // Unmapped reads as zero
        end
        if (memModel.exists(int'(addr))) begin
            value = memModel[int'(addr)];
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic addStep(input hackWord_t instr, input logic strobe, input hackWord_t code);
        progTab[tabLen]    = instr;
        keyTab[tabLen]     = strobe;
        keyCodeTab[tabLen] = code;
        tabLen++;
    endtask

    task automatic buildProgram();
        logic [31:0] rnd;
        int          p;
        logic [14:0] aluAddr;
        // Each jump code against D of -1, 0 and 1, filler skipped when taken
        for (int j = 0; j < 8; j++) begin
            for (int v = 0; v < 3; v++) begin
                addStep(encodeC(1'b0, dSetComp[v], 3'b010, 3'b000), 1'b0, '0);
                p = tabLen;
                addStep(encodeA(15'(p + 3)), 1'b0, '0);                      // Target
                addStep(encodeC(1'b0, 6'b001100, 3'b000, 3'(j)), 1'b0, '0);   // D;Jxx
                addStep(encodeC(1'b0, 6'b011111, 3'b010, 3'b000), 1'b0, '0);  // D=D+1
            end
        end
        // All comp codes into M, A source then M source
        rnd = $random(seed);
        addStep(encodeA(rnd[14:0]), 1'b0, '0);
        addStep(encodeC(1'b0, 6'b110000, 3'b010, 3'b000), 1'b0, '0);          // D=A
        rnd = $random(seed);
        aluAddr = {1'b0, rnd[13:0]};            // Inside data RAM
        addStep(encodeA(aluAddr), 1'b0, '0);
        for (int c = 0; c < 18; c++) begin
            addStep(encodeC(1'b0, compList[c], 3'b001, 3'b000), 1'b0, '0);
            addStep(encodeC(1'b1, compList[c], 3'b001, 3'b000), 1'b0, '0);
        end
        // Write then read back across RAM, screen, keyboard and unmapped space
        rnd = $random(seed);
        addStep(encodeA(rnd[14:0]), 1'b0, '0);
        addStep(encodeC(1'b0, 6'b110000, 3'b010, 3'b000), 1'b0, '0);          // D=A
        addStep(encodeA(15'd300), 1'b0, '0);
        addStep(encodeC(1'b0, 6'b001100, 3'b001, 3'b000), 1'b0, '0);          // M=D
        addStep(encodeC(1'b1, 6'b110111, 3'b010, 3'b000), 1'b0, '0);          // D=M+1
        addStep(encodeA(SCREEN_BASE + 15'd116), 1'b0, '0);
        addStep(encodeC(1'b0, 6'b001100, 3'b001, 3'b000), 1'b0, '0);
        addStep(encodeC(1'b1, 6'b110000, 3'b010, 3'b000), 1'b0, '0);          // D=M
        addStep(encodeA(15'd24575), 1'b0, '0);                                // Last screen word
        addStep(encodeC(1'b0, 6'b111010, 3'b001, 3'b000), 1'b0, '0);          // M=-1
        addStep(encodeC(1'b1, 6'b110000, 3'b010, 3'b000), 1'b0, '0);
        addStep(encodeA(KBD_ADDR), 1'b0, '0);
        addStep(encodeC(1'b0, 6'b001100, 3'b001, 3'b000), 1'b0, '0);          // Dropped write
        addStep(encodeC(1'b1, 6'b110000, 3'b010, 3'b000), 1'b0, '0);
        addStep(encodeA(15'd24600), 1'b0, '0);
        addStep(encodeC(1'b0, 6'b111111, 3'b001, 3'b000), 1'b0, '0);
        addStep(encodeC(1'b1, 6'b110000, 3'b010, 3'b000), 1'b0, '0);          // Reads zero
        // Keyboard strobes, held value and last strobe wins
        rnd = $random(seed);
        addStep(encodeA(KBD_ADDR), 1'b1, rnd[15:0]);
        addStep(encodeC(1'b1, 6'b110000, 3'b010, 3'b000), 1'b0, '0);
        addStep(encodeC(1'b0, 6'b011111, 3'b010, 3'b000), 1'b0, '0);
        addStep(encodeC(1'b1, 6'b110000, 3'b010, 3'b000), 1'b0, '0);          // Still held
        rnd = $random(seed);
        addStep(encodeA(15'd5), 1'b1, rnd[15:0]);
        rnd = $random(seed);
        addStep(encodeA(KBD_ADDR), 1'b1, rnd[15:0]);
        addStep(encodeC(1'b1, 6'b110000, 3'b010, 3'b000), 1'b0, '0);
        addStep(encodeC(1'b0, 6'b001100, 3'b001, 3'b000), 1'b0, '0);
        addStep(encodeC(1'b1, 6'b110000, 3'b010, 3'b000), 1'b0, '0);
    endtask

    task automatic checkReset();
        assert (pc == 15'd0) else reportMismatch($sformatf("pc %0d in reset, expected 0", pc));
        assert (memReqOut.we == 1'b0) else reportMismatch("memory write during reset");
    endtask

    // Compare this cycle against the model, then advance the model one instruction
    task automatic checkAndStep();
        int        entry;
        int        errBefore;
        cInstr_t   ci;
        hackWord_t mVal;
        hackWord_t result;
        hackAddr_t pcNext;
        logic      mKnown;
        logic      expWe;
        logic      taken;
        entry     = int'(pcModel);
        errBefore = errors;
        ci        = cInstr_t'(progTab[entry]);
        mKnown    = modelRead(aModel[14:0], mVal);
        result    = refAlu(ci.comp, dModel, ci.aSel ? mVal : aModel);
        expWe     = ci.isC && ci.dest[0];
        assert (pc == pcModel)
            else reportMismatch($sformatf("pc %0d, expected %0d", pc, pcModel));
        assert (memReqOut.addr == aModel[14:0])
            else reportMismatch($sformatf("addr %0d, expected %0d", memReqOut.addr, aModel));
        assert (memReqOut.we == expWe)
            else reportMismatch($sformatf("we %0b, expected %0b", memReqOut.we, expWe));
        if (ci.isC && (mKnown || !ci.aSel)) begin
            assert (memReqOut.data == result)
                else reportMismatch($sformatf("outM %h, expected %h", memReqOut.data, result));
        end
        if (mKnown) begin
            assert (inM == mVal)
                else reportMismatch($sformatf("inM %h, expected %h", inM, mVal));
        end
        taken  = ci.isC && ((ci.jump[2] && result[15]) || (ci.jump[1] && result == 16'd0)
                 || (ci.jump[0] && !result[15] && result != 16'd0));
        pcNext = taken ? aModel[14:0] : pcModel + 15'd1;   // Target is A before update
        if (!ci.isC) begin
            aModel = progTab[entry];
        end else begin
            if (ci.dest[0] && aModel[14:0] < KBD_ADDR) begin
                memModel[int'(aModel[14:0])] = result;
            end
            if (ci.dest[1]) begin
                dModel = result;
            end
            if (ci.dest[2]) begin
                aModel = result;
            end
        end
        if (keyTab[entry]) begin
            kbdModel = keyCodeTab[entry];       // Seen from next cycle
        end
        pcModel = pcNext;
        $display("entry %0d pc %0d %s", entry, pc, (errors == errBefore) ? "ok" : "FAILED");
    endtask

    initial begin
        clock    = 1'b0;
        rstN     = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        keyValid = 1'b0;
        keyCode  = '0;
        seed     = 32'hd4d08331;
        errors   = 0;
        steps    = 0;
        tabLen   = 0;
        aModel   = '0;
        dModel   = '0;
        pcModel  = '0;
        kbdModel = '0;
        buildProgram();
        cycleLimit = 2 * tabLen + 20;

        for (int i = 0; i < tabLen; i++) begin   // ROM load while in reset
            @(negedge clock);
            checkReset();
            progWe   = 1'b1;
            progAddr = i[14:0];
            progData = progTab[i];
        end
        @(negedge clock);
        progWe = 1'b0;
        repeat (4) begin                        // Reset held 4 cycles past the load
            @(negedge clock);
            checkReset();
        end

        while (int'(pcModel) < tabLen) begin
            @(negedge clock);
            rstN     = 1'b1;
            keyValid = keyTab[int'(pcModel)];
            keyCode  = keyCodeTab[int'(pcModel)];
            #sampleOffset;
            checkAndStep();
            steps++;
        end
        @(negedge clock);
        keyValid = 1'b0;

        $display("Ran %0d steps over %0d entries, %0d errors", steps, tabLen, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- design/hackComputer.sv
`timescale 1ns/1ps

module hackComputer #(
    parameter int ramAddrBits = 14,             // Data RAM depth
    parameter int romAddrBits = 15              // Instruction ROM depth
) (
    input  logic               clock,
    input  logic               rstN,
    input  logic               progWe,          // ROM load strobe, reset only
    input  hackPkg::hackAddr_t progAddr,
    input  hackPkg::hackWord_t progData,
    input  logic               keyValid,
    input  hackPkg::hackWord_t keyCode,
    output hackPkg::memReq_t   memReqOut,
    output hackPkg::hackAddr_t pc,
    output hackPkg::hackWord_t inM
);
    import hackPkg::*;

    hackWord_t instr;
    hackAddr_t romAddr;

    // Loader owns the ROM port while held in reset
    assign romAddr = rstN ? pc : progAddr;

    hackRam #(.addrBits(romAddrBits)) rom (
        .clock (clock),
        .we    (progWe && !rstN),               // Program load gated by reset
        .addr  (romAddr[romAddrBits-1:0]),
        .wdata (progData),
        .rdata (instr)
    );

    hackCpu cpu (
        .clock  (clock),
        .rstN   (rstN),
        .instr  (instr),
        .inM    (inM),
        .memReq (memReqOut),
        .pc     (pc)
    );

    hackMemoryMap #(.ramAddrBits(ramAddrBits)) memMap (
        .clock    (clock),
        .rstN     (rstN),
        .memReq   (memReqOut),
        .keyValid (keyValid),
        .keyCode  (keyCode),
        .inM      (inM)
    );

endmodule

//--- design/hackMemoryMap.sv
`timescale 1ns/1ps

module hackMemoryMap #(
    parameter int ramAddrBits = 14              // Data RAM depth, below 14 aliases
) (
    input  logic               clock,
    input  logic               rstN,
    input  hackPkg::memReq_t   memReq,
    input  logic               keyValid,        // Single-cycle strobe
    input  hackPkg::hackWord_t keyCode,
    output hackPkg::hackWord_t inM
);
    import hackPkg::*;

    localparam int screenAddrBits = 13;         // 8K words

    logic      inRam;
    logic      inScreen;
    logic      isKbd;
    hackWord_t ramData;
    hackWord_t screenData;
    hackWord_t kbdReg;

    // Region decode
    assign inRam    = memReq.addr < SCREEN_BASE;
    assign inScreen = !inRam && (memReq.addr < KBD_ADDR);
    assign isKbd    = memReq.addr == KBD_ADDR;   // Read-only, writes dropped

    hackRam #(.addrBits(ramAddrBits)) dataRam (
        .clock (clock),
        .we    (memReq.we && inRam),
        .addr  (memReq.addr[ramAddrBits-1:0]),
        .wdata (memReq.data),
        .rdata (ramData)
    );

    hackRam #(.addrBits(screenAddrBits)) screenRam (
        .clock (clock),
        .we    (memReq.we && inScreen),
        .addr  (memReq.addr[screenAddrBits-1:0]),   // Offset from SCREEN_BASE
        .wdata (memReq.data),
        .rdata (screenData)
    );

    // Keyboard register, last strobe wins
    always_ff @(posedge clock) begin
        if (!rstN) begin
            kbdReg <= '0;
        end else if (keyValid) begin
            kbdReg <= keyCode;
        end
    end

    // Read mux
    always_comb begin
        if (inRam) begin
            inM = ramData;
        end else if (inScreen) begin
            inM = screenData;
        end else if (isKbd) begin
            inM = kbdReg;
        end else begin
            inM = '0;                           // Unmapped space
        end
    end

    keyValidKnown: assert property (
        @(posedge clock) disable iff (!rstN) !$isunknown(keyValid)
    ) else $error("keyValid unknown after reset");

endmodule

//--- design/hackCpu.sv
`timescale 1ns/1ps

module hackCpu (
    input  logic               clock,
    input  logic               rstN,
    input  hackPkg::hackWord_t instr,           // From ROM at pc
    input  hackPkg::hackWord_t inM,             // Memory read data
    output hackPkg::memReq_t   memReq,
    output hackPkg::hackAddr_t pc
);
    import hackPkg::*;

    cInstr_t   cInstr;
    hackWord_t aReg;
    hackWord_t dReg;
    hackWord_t aluY;
    hackWord_t aluOut;
    aluFlags_t flags;
    logic      isC;
    logic      loadA;
    logic      loadD;
    logic      jumpHit;
    logic      pcLoad;

    assign cInstr = cInstr_t'(instr);           // Decode view
    assign isC    = cInstr.isC;

    // ALU operand select, a-bit picks M over A
    assign aluY = cInstr.aSel ? inM : aReg;

    hackAlu alu (
        .x     (dReg),
        .y     (aluY),
        .ctl   (cInstr.comp),
        .out   (aluOut),
        .flags (flags)
    );

    // Register load enables
    assign loadA = !isC || cInstr.dest[2];      // A-instr or dest A
    assign loadD = isC && cInstr.dest[1];       // dest D

    // Jump condition against the flags of this cycle's result
    assign jumpHit = (cInstr.jump[2] && flags.ng)
                   || (cInstr.jump[1] && flags.zr)
                   || (cInstr.jump[0] && !(flags.ng || flags.zr));
    assign pcLoad  = isC && jumpHit;            // A-instr never jumps

    hackPc pcUnit (
        .clock     (clock),
        .rstN      (rstN),
        .load      (pcLoad),
        .loadValue (aReg[14:0]),                // Target is A before update
        .pc        (pc)
    );

    always_ff @(posedge clock) begin
        if (!rstN) begin
            aReg <= '0;
            dReg <= '0;
        end else begin
            if (loadA) begin
                aReg <= isC ? aluOut : instr;   // Constant load on A-instr
            end
            if (loadD) begin
                dReg <= aluOut;
            end
        end
    end

    // Memory side
    assign memReq.addr = aReg[14:0];            // addressM
    assign memReq.data = aluOut;                // outM
    assign memReq.we   = isC && cInstr.dest[0] && rstN;   // writeM, held off in reset

    // No memory write may reach the map while held in reset
    noWriteInReset: assert property (
        @(posedge clock) !rstN |-> !memReq.we
    ) else $error("Memory write requested during reset");

endmodule

//--- design/hackRam.sv
`timescale 1ns/1ps

module hackRam #(
    parameter int addrBits = 14                 // Depth is 2**addrBits words
) (
    input  logic                clock,
    input  logic                we,
    input  logic [addrBits-1:0] addr,
    input  hackPkg::hackWord_t  wdata,
    output hackPkg::hackWord_t  rdata
);
    import hackPkg::*;

    hackWord_t mem [0:(1 << addrBits) - 1];

    // Combinational read, same cycle as the address
    assign rdata = mem[addr];

    // Write lands at the rising edge
    always_ff @(posedge clock) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

//--- design/hackPc.sv
`timescale 1ns/1ps

module hackPc (
    input  logic               clock,
    input  logic               rstN,
    input  logic               load,            // Jump taken
    input  hackPkg::hackAddr_t loadValue,       // Jump target from A
    output hackPkg::hackAddr_t pc
);
    import hackPkg::*;

    hackAddr_t pcNext;

    assign pcNext = load ? loadValue : pc + 15'd1;   // Jump or step

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= '0;                           // Restart at address 0
        end else begin
            pc <= pcNext;
        end
    end

    // Sequential flow must step by exactly one instruction
    pcStep: assert property (
        @(posedge clock) disable iff (!rstN)
        !load |=> pc == $past(pc) + 15'd1
    ) else $error("PC did not advance by one without a jump");

endmodule

//--- design/hackAlu.sv
`timescale 1ns/1ps

module hackAlu (
    input  hackPkg::hackWord_t x,               // D operand
    input  hackPkg::hackWord_t y,               // A or M operand
    input  logic [5:0]         ctl,             // zx nx zy ny f no
    output hackPkg::hackWord_t out,
    output hackPkg::aluFlags_t flags
);
    import hackPkg::*;

    hackWord_t xZero;
    hackWord_t xNeg;
    hackWord_t yZero;
    hackWord_t yNeg;
    hackWord_t fOut;

    // X preprocessing
    assign xZero = ctl[5] ? '0 : x;             // zx
    assign xNeg  = ctl[4] ? ~xZero : xZero;     // nx

    // Y preprocessing
    assign yZero = ctl[3] ? '0 : y;             // zy
    assign yNeg  = ctl[2] ? ~yZero : yZero;     // ny

    // Function select, add or bitwise and
    assign fOut = ctl[1] ? (xNeg + yNeg) : (xNeg & yNeg);

    assign out = ctl[0] ? ~fOut : fOut;         // no

    // Status derived from final result
    assign flags.zr = (out == '0);
    assign flags.ng = out[15];                  // Sign bit

endmodule

//--- design/hackPkg.sv
package hackPkg;

    // Data word and address widths of the Hack machine
    typedef logic [15:0] hackWord_t;            // ALU, registers, memory contents
    typedef logic [14:0] hackAddr_t;            // Shared by data and instruction space

    // C-instruction overlay, MSB first as in the Hack spec
    typedef struct packed {
        logic       isC;                        // Set for C-instruction
        logic [1:0] pad;                        // Always ones in valid code
        logic       aSel;                       // Y operand is M, not A
        logic [5:0] comp;                       // zx nx zy ny f no
        logic [2:0] dest;                       // A D M
        logic [2:0] jump;                       // lt eq gt
    } cInstr_t;

    // ALU status flags
    typedef struct packed {
        logic zr;                               // Result is zero
        logic ng;                               // Result is negative
    } aluFlags_t;

    // Data-memory request from the CPU, 32 bits
    typedef struct packed {
        hackAddr_t addr;                        // Current A register
        hackWord_t data;                        // ALU result (outM)
        logic      we;                          // writeM
    } memReq_t;

    // Memory map boundaries
    localparam hackAddr_t SCREEN_BASE = 15'd16384;   // Screen RAM start
    localparam hackAddr_t KBD_ADDR    = 15'd24576;   // Keyboard register

endpackage
